//--- include/dma_bus_config.svh
/* Fixed widths and sizes for the DMA system bus.
   Included by the package and by every RTL file */
`ifndef DMA_BUS_CONFIG_SVH
`define DMA_BUS_CONFIG_SVH

// Bus word width in bits
`define DATA_W 32

// Byte address width
`define ADDR_W 16

// Work-unit line width, one whole transfer
`define LINE_W 128

// Beats per transfer
`define BURST_LEN 4

// RAM depth in bus words
`define MEM_WORDS 256

`endif

//--- hdl/dma_bus_pkg.sv
/* Shared types for the DMA bus controllers and the bus interface.
   Import with a wildcard inside the body of the module that uses it */
`include "dma_bus_config.svh"

package dma_bus_pkg;

   // Channel controller state
   typedef enum logic [2:0] {
      // Waiting for a work-unit request
      IDLE    = 3'd0,
      // Bus requested, waiting for the grant
      ST_BR   = 3'd1,
      // Bus owner, beat driven
      MSTR    = 3'd2,
      // Beat still driven, waiting for the acknowledge
      ST_WAIT = 3'd3,
      // Line presented to the work unit
      ST_RSP  = 3'd4
   } ctrl_state_t;

   // Bus opcode, one bit on the bus
   typedef enum logic {
      OP_READ  = 1'b0,
      OP_WRITE = 1'b1
   } bus_op_t;

   // Index of a beat within a burst
   typedef logic [$clog2(`BURST_LEN)-1:0] beat_t;

endpackage

//--- hdl/sys_bus_if.sv
/* System bus between the DMA channels, the arbiter and the memory.
   Masters use the master modport, the memory side uses the slave modport */
`timescale 1ns/1ps
`include "dma_bus_config.svh"

interface sys_bus_if;
   import dma_bus_pkg::*;

   // Byte address of the current beat
   logic [`ADDR_W-1:0] addr;
   // Read or write
   bus_op_t            op;
   // Write data for the current beat
   logic [`DATA_W-1:0] wdata;
   // Beat is on the bus, address and data stable
   logic               beat_valid;
   // One cycle acknowledge from the slave
   logic               ack;
   // Read data, valid in the ack cycle
   logic [`DATA_W-1:0] rdata;

   // Channel side
   modport master (
      output addr,
      output op,
      output wdata,
      output beat_valid,
      input  ack,
      input  rdata
   );

   // Memory side
   modport slave (
      input  addr,
      input  op,
      input  wdata,
      input  beat_valid,
      output ack,
      output rdata
   );

endinterface

//--- hdl/bus_arbiter.sv
/* Round-robin bus arbiter for two DMA channels.
   Routes the owner's beats to the memory and returns ack and rdata only to it */
`timescale 1ns/1ps
`include "dma_bus_config.svh"

module bus_arbiter (
   input  logic      bus_clk,
   input  logic      rst_n,
   input  logic      br0,
   input  logic      br1,
   output logic      bg0,
   output logic      bg1,
   sys_bus_if.slave  m0,
   sys_bus_if.slave  m1,
   sys_bus_if.master s
);
   // Registered ownership
   logic grant0_q;
   logic grant1_q;
   // Channel 1 was the last one served
   logic last1_q;
   logic bus_free;

   assign bus_free = !grant0_q && !grant1_q;

   always_ff @(posedge bus_clk) begin
      if (!rst_n) begin
         grant0_q <= 1'b0;
         grant1_q <= 1'b0;
         // Channel 0 wins the first tie
         last1_q  <= 1'b1;
      end else if (bus_free) begin
         // On a tie the channel not served last wins
         if (br0 && (!br1 || last1_q)) begin
            grant0_q <= 1'b1;
            last1_q  <= 1'b0;
         end else if (br1) begin
            grant1_q <= 1'b1;
            last1_q  <= 1'b1;
         end
      end else begin
         // Grant holds with its request, drops the cycle after it falls
         grant0_q <= grant0_q && br0;
         grant1_q <= grant1_q && br1;
      end
   end

   // Grant seen by a channel only while it still requests
   assign bg0 = grant0_q && br0;
   assign bg1 = grant1_q && br1;

   // Owner's signals onto the memory side
   assign s.addr       = grant1_q ? m1.addr  : m0.addr;
   assign s.op         = grant1_q ? m1.op    : m0.op;
   assign s.wdata      = grant1_q ? m1.wdata : m0.wdata;
   assign s.beat_valid = (grant0_q && m0.beat_valid) || (grant1_q && m1.beat_valid);

   // Response back to the owner, zero to the other
   assign m0.ack   = grant0_q && s.ack;
   assign m1.ack   = grant1_q && s.ack;
   assign m0.rdata = grant0_q ? s.rdata : '0;
   assign m1.rdata = grant1_q ? s.rdata : '0;

endmodule

//--- hdl/dma_bus_controller.sv
/* One DMA channel: takes a 16-byte work-unit request and moves it as a
   four-beat burst once the arbiter grants the bus */
`timescale 1ns/1ps
`include "dma_bus_config.svh"

module dma_bus_controller (
   input  logic                bus_clk,
   input  logic                rst_n,
   // Work-unit request
   input  logic                req_valid,
   input  logic                req_write,
   output logic                req_ready,
   input  logic [`ADDR_W-1:0]  req_addr,
   input  logic [`LINE_W-1:0]  req_wdata,
   // Work-unit response
   output logic                rsp_valid,
   input  logic                rsp_ready,
   output logic [`LINE_W-1:0]  rsp_rdata,
   // Arbiter handshake
   output logic                br,
   input  logic                bg,
   sys_bus_if.master           bus
);
   import dma_bus_pkg::*;

   ctrl_state_t        state_q;
   ctrl_state_t        state_d;
   beat_t              beat_q;
   logic               ready_q;
   logic               accept;
   logic               beat_done;
   logic               last_beat;
   // Latched request
   bus_op_t            op_q;
   logic [`ADDR_W-1:0] addr_q;
   logic [`LINE_W-1:0] wline_q;
   // Read line, filled one beat at a time
   logic [`LINE_W-1:0] rline_q;

   assign accept    = req_valid && req_ready;
   assign beat_done = (state_q == ST_WAIT) && bus.ack;
   assign last_beat = (beat_q == beat_t'(`BURST_LEN - 1));

   // Next state
   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            if (accept) begin
               state_d = ST_BR;
            end
         end
         ST_BR: begin
            // First beat goes out the cycle after the grant
            if (bg) begin
               state_d = MSTR;
            end
         end
         MSTR: begin
            state_d = ST_WAIT;
         end
         ST_WAIT: begin
            if (bus.ack) begin
               state_d = last_beat ? ST_RSP : MSTR;
            end
         end
         ST_RSP: begin
            if (rsp_ready) begin
               state_d = IDLE;
            end
         end
         default: begin
            state_d = IDLE;
         end
      endcase
   end

   // Control state
   always_ff @(posedge bus_clk) begin
      if (!rst_n) begin
         state_q <= IDLE;
         beat_q  <= '0;
         ready_q <= 1'b0;
      end else begin
         state_q <= state_d;
         // Ready follows IDLE one cycle late, so low right after reset
         ready_q <= (state_d == IDLE);
         if (state_q == IDLE) begin
            beat_q <= '0;
         end else if (beat_done) begin
            beat_q <= beat_q + 1'b1;
         end
      end
   end

   // Request latch and read assembly
   always_ff @(posedge bus_clk) begin
      if (accept) begin
         op_q    <= req_write ? OP_WRITE : OP_READ;
         addr_q  <= req_addr;
         wline_q <= req_wdata;
      end
      // Beat k lands in bits 32k+31:32k
      if (beat_done && (op_q == OP_READ)) begin
         rline_q[beat_q*`DATA_W +: `DATA_W] <= bus.rdata;
      end
   end

   assign req_ready = ready_q;

   // Bus held from request until the last acknowledge
   assign br = (state_q == ST_BR) || (state_q == MSTR) || (state_q == ST_WAIT);

   // Beat k at req_addr plus 4k
   assign bus.addr       = addr_q + {{(`ADDR_W-4){1'b0}}, beat_q, 2'b00};
   assign bus.op         = op_q;
   assign bus.wdata      = wline_q[beat_q*`DATA_W +: `DATA_W];
   assign bus.beat_valid = (state_q == MSTR) || (state_q == ST_WAIT);

   // Line held for the work unit until taken
   assign rsp_valid = (state_q == ST_RSP);
   assign rsp_rdata = rline_q;

endmodule

//--- hdl/mem_bus_controller.sv
/* Memory-side bus controller with a 256-word RAM behind it.
   Answers every beat with a single registered acknowledge */
`timescale 1ns/1ps
`include "dma_bus_config.svh"

module mem_bus_controller (
   input  logic     bus_clk,
   input  logic     rst_n,
   sys_bus_if.slave bus
);
   import dma_bus_pkg::*;

   // RAM word array, no reset of its own
   logic [`DATA_W-1:0] ram [`MEM_WORDS];

   // Word index from the byte address
   logic [$clog2(`MEM_WORDS)-1:0] idx;
   // Clear sweep over the RAM after reset
   logic [$clog2(`MEM_WORDS)-1:0] clr_cnt_q;
   logic                          clear_done_q;
   // Set the cycle after a beat is first seen, doubles as ack
   logic                          pending_q;
   logic                          first_seen;
   logic [`DATA_W-1:0]            rdata_q;

   // Bits above 9 are ignored, so such addresses alias
   assign idx = bus.addr[$clog2(`MEM_WORDS)+1:2];

   // New beat, not yet acknowledged
   assign first_seen = bus.beat_valid && !pending_q;

   // Control state
   always_ff @(posedge bus_clk) begin
      if (!rst_n) begin
         clr_cnt_q    <= '0;
         clear_done_q <= 1'b0;
         pending_q    <= 1'b0;
      end else begin
         if (!clear_done_q) begin
            clr_cnt_q <= clr_cnt_q + 1'b1;
            // Last word cleared this cycle
            if (clr_cnt_q == {$clog2(`MEM_WORDS){1'b1}}) begin
               clear_done_q <= 1'b1;
            end
         end
         // No acknowledge while the sweep runs
         pending_q <= first_seen && clear_done_q;
      end
   end

   // RAM port: clear sweep first, then bus writes
   always_ff @(posedge bus_clk) begin
      if (!clear_done_q) begin
         ram[clr_cnt_q] <= '0;
      end else if (pending_q && (bus.op == OP_WRITE)) begin
         // Write lands on the ack cycle
         ram[idx] <= bus.wdata;
      end
   end

   // Read sampled on first sight, presented with ack
   always_ff @(posedge bus_clk) begin
      if (first_seen) begin
         rdata_q <= ram[idx];
      end
   end

   assign bus.ack   = pending_q;
   assign bus.rdata = rdata_q;

endmodule

//--- hdl/dma_bus_top.sv
/* Shared bus system with two DMA channels, the arbiter and the memory.
   Each channel's work-unit ports appear as plain ports prefixed ch0_ and ch1_ */
`timescale 1ns/1ps
`include "dma_bus_config.svh"

module dma_bus_top (
   input  logic               bus_clk,
   input  logic               rst_n,
   // Channel 0 work unit
   input  logic               ch0_req_valid,
   input  logic               ch0_req_write,
   output logic               ch0_req_ready,
   input  logic [`ADDR_W-1:0] ch0_req_addr,
   input  logic [`LINE_W-1:0] ch0_req_wdata,
   output logic               ch0_rsp_valid,
   input  logic               ch0_rsp_ready,
   output logic [`LINE_W-1:0] ch0_rsp_rdata,
   // Channel 1 work unit
   input  logic               ch1_req_valid,
   input  logic               ch1_req_write,
   output logic               ch1_req_ready,
   input  logic [`ADDR_W-1:0] ch1_req_addr,
   input  logic [`LINE_W-1:0] ch1_req_wdata,
   output logic               ch1_rsp_valid,
   input  logic               ch1_rsp_ready,
   output logic [`LINE_W-1:0] ch1_rsp_rdata
);
   // Request and grant pairs
   logic br0;
   logic br1;
   logic bg0;
   logic bg1;

   // Channel legs and the memory leg of the bus
   sys_bus_if m0_bus ();
   sys_bus_if m1_bus ();
   sys_bus_if s_bus ();

   dma_bus_controller dma_ch0_inst (
      .bus_clk(bus_clk), .rst_n(rst_n),
      .req_valid(ch0_req_valid), .req_write(ch0_req_write), .req_ready(ch0_req_ready),
      .req_addr(ch0_req_addr), .req_wdata(ch0_req_wdata),
      .rsp_valid(ch0_rsp_valid), .rsp_ready(ch0_rsp_ready), .rsp_rdata(ch0_rsp_rdata),
      .br(br0), .bg(bg0), .bus(m0_bus.master)
   );

   dma_bus_controller dma_ch1_inst (
      .bus_clk(bus_clk), .rst_n(rst_n),
      .req_valid(ch1_req_valid), .req_write(ch1_req_write), .req_ready(ch1_req_ready),
      .req_addr(ch1_req_addr), .req_wdata(ch1_req_wdata),
      .rsp_valid(ch1_rsp_valid), .rsp_ready(ch1_rsp_ready), .rsp_rdata(ch1_rsp_rdata),
      .br(br1), .bg(bg1), .bus(m1_bus.master)
   );

   bus_arbiter arbiter_inst (
      .bus_clk(bus_clk), .rst_n(rst_n),
      .br0(br0), .br1(br1), .bg0(bg0), .bg1(bg1),
      .m0(m0_bus.slave), .m1(m1_bus.slave), .s(s_bus.master)
   );

   mem_bus_controller mem_inst (
      .bus_clk(bus_clk), .rst_n(rst_n), .bus(s_bus.slave)
   );

endmodule

//--- bench/dma_bus_properties.sv
/* Bound checks on bus arbitration, the beat handshake and response hold.
   Bound into the arbiter and into each DMA channel */
`timescale 1ns/1ps
`include "dma_bus_config.svh"

module dma_bus_properties (
   input logic               bus_clk,
   input logic               rst_n,
   input logic [1:0]         gnt,
   input logic [1:0]         req,
   input logic               beat_valid,
   input logic               ack,
   input logic               rsp_valid,
   input logic               rsp_ready,
   input logic [`LINE_W-1:0] rsp_rdata
);
   // One bus owner at a time
   a_one_grant: assert property (@(posedge bus_clk) disable iff (!rst_n)
      !(gnt[0] && gnt[1]))
      else $error("both bus grants high");

   // Grant outlives its own request by one cycle at most
   a_grant_req: assert property (@(posedge bus_clk) disable iff (!rst_n)
      ((gnt & ~req) != 2'b00) |-> ((gnt & ~$past(req)) == 2'b00))
      else $error("bus grant without request");

   a_ack_valid: assert property (@(posedge bus_clk) disable iff (!rst_n)
      ack |-> beat_valid)
      else $error("ack without beat_valid");

   // Line held under back-pressure
   a_rsp_hold: assert property (@(posedge bus_clk) disable iff (!rst_n)
      (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_rdata)))
      else $error("response changed while stalled");

endmodule

//--- bench/dma_bus_tb.sv
/* Testbench for the two-channel DMA bus. Replays the request list from the
   test data file and checks read lines against a word-level memory model */
`timescale 1ns/1ps
`include "dma_bus_config.svh"

module dma_bus_tb;
   typedef logic [`LINE_W-1:0] line_t;
   typedef logic [`ADDR_W-1:0] addr_t;
   typedef logic [$clog2(`MEM_WORDS)-1:0] widx_t;

   // Clock period in ns
   localparam int clk_ns = 10;
   // One cycle to release, one to regrant, eight of burst, one to respond
   localparam int handover_cycles = 11;

   logic       bus_clk;
   logic       rst_n;
   // Work-unit side, indexed by channel
   logic [1:0] req_valid;
   logic [1:0] req_write;
   logic [1:0] req_ready;
   addr_t      req_addr [2];
   line_t      req_wdata [2];
   logic [1:0] rsp_valid;
   logic [1:0] rsp_ready;
   line_t      rsp_rdata [2];

   // Request list, one entry per data line
   int    t_grp [$];
   bit    t_ch [$];
   bit    t_write [$];
   addr_t t_addr [$];
   line_t t_wdata [$];
   line_t t_exp [$];
   int    t_stall [$];

   // Word-level memory model, updated in response order
   logic [`DATA_W-1:0] ref_mem [`MEM_WORDS];
   // Channels in the order their responses first show up
   bit rsp_order [$];
   // Time each channel's response was first seen
   time rsp_time [2];
   bit last_served;
   bit loaded;
   int errors;
   int checks;

   dma_bus_top dma_bus_top_inst (
      .bus_clk(bus_clk), .rst_n(rst_n),
      .ch0_req_valid(req_valid[0]), .ch0_req_write(req_write[0]),
      .ch0_req_ready(req_ready[0]), .ch0_req_addr(req_addr[0]),
      .ch0_req_wdata(req_wdata[0]), .ch0_rsp_valid(rsp_valid[0]),
      .ch0_rsp_ready(rsp_ready[0]), .ch0_rsp_rdata(rsp_rdata[0]),
      .ch1_req_valid(req_valid[1]), .ch1_req_write(req_write[1]),
      .ch1_req_ready(req_ready[1]), .ch1_req_addr(req_addr[1]),
      .ch1_req_wdata(req_wdata[1]), .ch1_rsp_valid(rsp_valid[1]),
      .ch1_rsp_ready(rsp_ready[1]), .ch1_rsp_rdata(rsp_rdata[1])
   );

   // Arbitration and slave-side handshake checks
   bind bus_arbiter dma_bus_properties arb_props_inst (
      .bus_clk(bus_clk), .rst_n(rst_n), .gnt({grant1_q, grant0_q}), .req({br1, br0}),
      .beat_valid(s.beat_valid), .ack(s.ack),
      .rsp_valid(1'b0), .rsp_ready(1'b1), .rsp_rdata('0)
   );

   // Per-channel handshake and response hold checks
   bind dma_bus_controller dma_bus_properties ch_props_inst (
      .bus_clk(bus_clk), .rst_n(rst_n), .gnt({1'b0, bg}), .req({1'b0, br}),
      .beat_valid(bus.beat_valid), .ack(bus.ack),
      .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_rdata(rsp_rdata)
   );

   initial begin
      bus_clk = 1'b0;
      forever #(clk_ns / 2) bus_clk = ~bus_clk;
   end

   task automatic check_value(input string name, input line_t got, input line_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   // RAM word hit by beat k, address bits above 9 dropped
   function automatic widx_t word_index(input addr_t addr, input int k);
      addr_t baddr;
      baddr = addr + addr_t'(k * 4);
      return baddr[$clog2(`MEM_WORDS)+1:2];
   endfunction

   // Beat 0 sits in the low word of the line
   function automatic line_t model_read(input addr_t addr);
      line_t line;
      int    k;
      for (k = 0; k < `BURST_LEN; k++) begin
         line[k*`DATA_W +: `DATA_W] = ref_mem[word_index(addr, k)];
      end
      return line;
   endfunction

   task automatic model_write(input addr_t addr, input line_t line);
      int k;
      for (k = 0; k < `BURST_LEN; k++) begin
         ref_mem[word_index(addr, k)] = line[k*`DATA_W +: `DATA_W];
      end
   endtask

   task automatic load_tests();
      int               fd;
      int               n;
      int               grp;
      int               ch;
      int               op;
      int               stall;
      addr_t            addr;
      line_t            wdata;
      line_t            exp;
      logic [8*256-1:0] header;
      fd = $fopen("bench/dma_testdata.txt", "r");
      if (fd == 0) begin
         errors++;
         $display("Error: cannot open bench/dma_testdata.txt");
      end else begin
         // Two lines of column description
         n = $fgets(header, fd);
         n = $fgets(header, fd);
         n = $fscanf(fd, "%d %d %d %h %h %h %d\n", grp, ch, op, addr, wdata, exp, stall);
         while (n == 7) begin
            t_grp.push_back(grp);
            t_ch.push_back(ch != 0);
            t_write.push_back(op != 0);
            t_addr.push_back(addr);
            t_wdata.push_back(wdata);
            t_exp.push_back(exp);
            t_stall.push_back(stall);
            n = $fscanf(fd, "%d %d %d %h %h %h %d\n", grp, ch, op, addr, wdata, exp, stall);
         end
         $fclose(fd);
         if (t_grp.size() == 0) begin
            errors++;
            $display("Error: the test data file holds no requests");
         end
      end
   endtask

   // Called on a rising edge with the channel idle
   task automatic run_request(input int idx);
      bit    ch;
      line_t held;
      ch = t_ch[idx];
      req_valid[ch] <= 1'b1;
      req_write[ch] <= t_write[idx];
      req_addr[ch]  <= t_addr[idx];
      req_wdata[ch] <= t_wdata[idx];
      do begin
         @(posedge bus_clk);
      end while (req_ready[ch] !== 1'b1);
      req_valid[ch] <= 1'b0;
      do begin
         @(posedge bus_clk);
      end while (rsp_valid[ch] !== 1'b1);
      rsp_order.push_back(ch);
      rsp_time[ch] = $time;
      held = rsp_rdata[ch];
      // Back-pressure, line and flags must hold
      repeat (t_stall[idx]) begin
         @(posedge bus_clk);
         check_value($sformatf("ch%0d_rsp_valid", ch), line_t'(rsp_valid[ch]), line_t'(1));
         check_value($sformatf("ch%0d_rsp_rdata", ch), rsp_rdata[ch], held);
         check_value($sformatf("ch%0d_req_ready", ch), line_t'(req_ready[ch]), line_t'(0));
      end
      rsp_ready[ch] <= 1'b1;
      @(posedge bus_clk);
      rsp_ready[ch] <= 1'b0;
      if (t_write[idx]) begin
         model_write(t_addr[idx], t_wdata[idx]);
      end else begin
         check_value($sformatf("ch%0d_rsp_rdata", ch), held, t_exp[idx]);
         check_value($sformatf("ch%0d_rsp_rdata vs model", ch), held, model_read(t_addr[idx]));
      end
   endtask

   task automatic run_group(input int first, input int count);
      bit exp_first;
      do begin
         @(posedge bus_clk);
      end while (req_ready !== 2'b11);
      rsp_order.delete();
      if (count == 2) begin
         fork
            run_request(first);
            run_request(first + 1);
         join
         // Tie goes to the channel not served last
         exp_first = !last_served;
         check_value("first_served_channel", line_t'(rsp_order[0]), line_t'(exp_first));
         // Bus passes on as soon as the first burst ends, stalled or not
         check_value("second_rsp_delay_ns",
                     line_t'(rsp_time[rsp_order[1]] - rsp_time[rsp_order[0]]),
                     line_t'(handover_cycles * clk_ns));
         last_served = !exp_first;
      end else begin
         run_request(first);
         last_served = t_ch[first];
      end
   endtask

   initial begin : main
      int i;
      int j;
      errors      = 0;
      checks      = 0;
      loaded      = 1'b0;
      // Channel 0 wins the first tie after reset
      last_served = 1'b1;
      rst_n       = 1'b0;
      req_valid   = '0;
      req_write   = '0;
      rsp_ready   = '0;
      req_addr    = '{default: '0};
      req_wdata   = '{default: '0};
      foreach (ref_mem[w]) begin
         ref_mem[w] = '0;
      end
      load_tests();
      loaded = 1'b1;
      repeat (3) @(posedge bus_clk);
      rst_n <= 1'b1;
      i = 0;
      while (i < t_grp.size()) begin
         j = i + 1;
         while (j < t_grp.size() && t_grp[j] == t_grp[i]) begin
            j++;
         end
         if (j - i > 2 || (j - i == 2 && t_ch[i] == t_ch[i + 1])) begin
            errors++;
            $display("Error: group %0d needs at most one request per channel", t_grp[i]);
         end else begin
            run_group(i, j - i);
         end
         i = j;
      end
      repeat (2) @(posedge bus_clk);
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0 && checks > 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

   // Memory clear plus a budget per request
   initial begin : watchdog
      wait (loaded);
      repeat (300 + 60 * t_grp.size()) @(posedge bus_clk);
      $display("Error: watchdog expired, a transfer never completed");
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("FAIL: see errors above");
      $finish;
   end

endmodule

//--- bench/dma_testdata.txt
# grp ch op(1=write) addr(hex) wdata(hex) expected_rdata(hex) rsp_ready_stall
# lines with the same grp start in the same cycle, expected_rdata is unused for writes
1 0 0 0040 00000000000000000000000000000000 00000000000000000000000000000000 0
1 1 0 0080 00000000000000000000000000000000 00000000000000000000000000000000 0
2 0 1 0100 0f1e2d3c4b5a69788796a5b4c3d2e1f0 00000000000000000000000000000000 0
3 0 0 0100 00000000000000000000000000000000 0f1e2d3c4b5a69788796a5b4c3d2e1f0 0
4 0 0 0100 00000000000000000000000000000000 0f1e2d3c4b5a69788796a5b4c3d2e1f0 0
4 1 1 0200 11112222333344445555666677778888 00000000000000000000000000000000 0
5 0 1 0300 c0c0c0c1c0c0c0c2c0c0c0c3c0c0c0c4 00000000000000000000000000000000 0
5 1 1 0300 d0d0d0d1d0d0d0d2d0d0d0d3d0d0d0d4 00000000000000000000000000000000 0
6 1 0 0300 00000000000000000000000000000000 c0c0c0c1c0c0c0c2c0c0c0c3c0c0c0c4 0
7 0 0 8300 00000000000000000000000000000000 c0c0c0c1c0c0c0c2c0c0c0c3c0c0c0c4 3
8 1 1 0740 e5e5e5e1e5e5e5e2e5e5e5e3e5e5e5e4 00000000000000000000000000000000 0
9 0 0 0340 00000000000000000000000000000000 e5e5e5e1e5e5e5e2e5e5e5e3e5e5e5e4 0
10 1 0 0200 00000000000000000000000000000000 11112222333344445555666677778888 20
10 0 0 0100 00000000000000000000000000000000 0f1e2d3c4b5a69788796a5b4c3d2e1f0 0
11 0 1 0400 0123456789abcdeffedcba9876543210 00000000000000000000000000000000 5
11 1 0 0300 00000000000000000000000000000000 c0c0c0c1c0c0c0c2c0c0c0c3c0c0c0c4 0
12 1 0 0400 00000000000000000000000000000000 0123456789abcdeffedcba9876543210 0

//--- verilog.f
+incdir+include
hdl/dma_bus_pkg.sv
hdl/sys_bus_if.sv
hdl/bus_arbiter.sv
hdl/dma_bus_controller.sv
hdl/mem_bus_controller.sv
hdl/dma_bus_top.sv
bench/dma_bus_properties.sv
bench/dma_bus_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the DMA bus testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f verilog.f --top-module dma_bus_tb -o Vdma_bus_tb
./obj_dir/Vdma_bus_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "PASS: all tests" sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi
